/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_top
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/bridge_assert.sv */
`default_nettype none

module bridge_assert (
  input wire                    heep_clk,
  input wire                    rst_instr_valid_to_regs,
  input wire obi_pkg::obi_req_t m0_req_i,
  input wire obi_pkg::obi_req_t m1_req_i,
  input wire                    m0_gnt_i,
  input wire                    m1_gnt_i,
  input wire                    clr_instr_i,
  input wire                    clr_addr_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // running count of assertion failures
  int fail_cnt = 0;

  // ------------------------------------------------------------
  // bus side
  // ------------------------------------------------------------
  // no grant without a request
  m0_gnt_has_req: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    m0_gnt_i |-> m0_req_i.req)
    else begin
      $error("bridge master granted without a request");
      fail_cnt++;
    end

  m1_gnt_has_req: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    m1_gnt_i |-> m1_req_i.req)
    else begin
      $error("window master granted without a request");
      fail_cnt++;
    end

  // losing master holds the whole request
  m0_req_held: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    (m0_req_i.req && !m0_gnt_i) |=> $stable(m0_req_i))
    else begin
      $error("bridge request changed before its grant");
      fail_cnt++;
    end

  m1_req_held: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    (m1_req_i.req && !m1_gnt_i) |=> $stable(m1_req_i))
    else begin
      $error("window request changed before its grant");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // status flag clears
  // ------------------------------------------------------------
  clr_instr_pulse: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    clr_instr_i |=> !clr_instr_i)
    else begin
      $error("instr_valid clear longer than one cycle");
      fail_cnt++;
    end

  clr_addr_pulse: assert property (@(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    clr_addr_i |=> !clr_addr_i)
    else begin
      $error("addr_valid clear longer than one cycle");
      fail_cnt++;
    end

endmodule

// arbiter instance with the clear inputs tied off
bind obi_arbiter bridge_assert u_bus_assert (
  .heep_clk                (heep_clk),
  .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
  .m0_req_i                (m0_req_i),
  .m1_req_i                (m1_req_i),
  .m0_gnt_i                (m0_resp_o.gnt),
  .m1_gnt_i                (m1_resp_o.gnt),
  .clr_instr_i             (1'b0),
  .clr_addr_i              (1'b0)
);

// register bank instance with the bus inputs tied off
bind bridge_regs bridge_assert u_flag_assert (
  .heep_clk                (heep_clk),
  .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
  .m0_req_i                ('0),
  .m1_req_i                ('0),
  .m0_gnt_i                (1'b0),
  .m1_gnt_i                (1'b0),
  .clr_instr_i             (clr_instr_i),
  .clr_addr_i              (clr_addr_i)
);

`default_nettype wire

/* test/tb_top.sv */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import host_reg_pkg::*;
  import obi_pkg::*;

  // ------------------------------------------------------------
  // run length and timeout
  // ------------------------------------------------------------
  localparam int N_WIN       = 16;
  localparam int N_MIX       = 16;
  localparam int POLL_MAX    = 64;
  // bridge writes, bridge reads, final sweep, window and mixed ops
  localparam int OPS_TOTAL   = 3 * MEM_WORDS + 2 * N_WIN + N_MIX + 8;
  // host accesses per op and cycles per access with margin
  localparam int ACC_PER_OP  = 16;
  localparam int CYC_PER_ACC = 8;
  localparam int MAX_CYCLES  = OPS_TOTAL * ACC_PER_OP * CYC_PER_ACC;

  logic                   heep_clk;
  logic                   rst_instr_valid_to_regs;
  logic [HOST_ADDR_W-1:0] usb_addr;
  logic [HOST_DATA_W-1:0] usb_wdata;
  logic                   usb_rdn;
  logic                   usb_wrn;
  logic                   usb_cen;
  logic [HOST_DATA_W-1:0] usb_rdata;

  // memory model and running address of the bridge
  logic [OBI_DATA_W-1:0]  mem_model [MEM_WORDS];
  logic [OBI_ADDR_W-1:0]  run_addr;

  integer seed;
  int     errors       = 0;
  int     checks       = 0;
  int     err_mark     = 0;
  int     chk_mark     = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     cycle_cnt    = 0;

  cw_bridge_top dut (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .usb_addr_i              (usb_addr),
    .usb_data_i              (usb_wdata),
    .usb_rdn_i               (usb_rdn),
    .usb_wrn_i               (usb_wrn),
    .usb_cen_i               (usb_cen),
    .usb_data_o              (usb_rdata)
  );

  initial heep_clk = 1'b0;
  always #5 heep_clk = ~heep_clk;

  always @(posedge heep_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [HOST_ADDR_W-1:0] reg_addr(input logic [REG_IDX_W-1:0] idx,
                                                      input logic [BYTECNT_W-1:0] bc);
    return {1'b0, idx, bc};
  endfunction

  function automatic logic [HOST_ADDR_W-1:0] win_addr(input logic [REG_IDX_W-1:0] idx,
                                                      input logic [BYTECNT_W-1:0] bc);
    return {1'b1, idx, bc};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // strobes low for two sampled cycles and the next access 3 cycles on
  task automatic write_byte(input logic [HOST_ADDR_W-1:0] a, input logic [HOST_DATA_W-1:0] d);
    @(posedge heep_clk);
    usb_addr  <= a;
    usb_wdata <= d;
    usb_cen   <= 1'b0;
    usb_wrn   <= 1'b0;
    repeat (2) @(posedge heep_clk);
    usb_cen <= 1'b1;
    usb_wrn <= 1'b1;
  endtask

  task automatic read_byte(input logic [HOST_ADDR_W-1:0] a, output logic [HOST_DATA_W-1:0] d);
    @(posedge heep_clk);
    usb_addr <= a;
    usb_cen  <= 1'b0;
    usb_rdn  <= 1'b0;
    repeat (2) @(posedge heep_clk);
    usb_cen <= 1'b1;
    usb_rdn <= 1'b1;
    // data out registered on this edge and settled at the falling edge
    @(negedge heep_clk);
    d = usb_rdata;
  endtask

  task automatic write_reg_word(input logic [REG_IDX_W-1:0] idx, input logic [31:0] w);
    for (int b = 0; b < 4; b++) begin
      write_byte(reg_addr(idx, BYTECNT_W'(b)), w[8*b +: 8]);
    end
  endtask

  task automatic read_reg_word(input logic [REG_IDX_W-1:0] idx, output logic [31:0] w);
    logic [7:0] d;
    for (int b = 0; b < 4; b++) begin
      read_byte(reg_addr(idx, BYTECNT_W'(b)), d);
      w[8*b +: 8] = d;
    end
  endtask

  // bounded status polling until the bit drops
  task automatic poll_clear(input int bit_pos);
    logic [7:0] st;
    int         n;
    n = 0;
    do begin
      read_byte(reg_addr(REG_STATUS, 2'd0), st);
      n++;
    end while (st[bit_pos] && (n < POLL_MAX));
    assert (!st[bit_pos]) else begin
      $display("status bit %0d still set after %0d polls", bit_pos, n);
      errors++;
    end
  endtask

  task automatic load_addr(input logic [31:0] a);
    write_reg_word(REG_ADDR, a);
    write_byte(reg_addr(REG_STATUS, 2'd0), 8'(1 << ST_ADDR_VALID));
    poll_clear(ST_ADDR_VALID);
    run_addr = a;
  endtask

  // one bridge op at the running address while the model advances by 4
  task automatic run_op(input bridge_op_e op, input logic [31:0] wdata);
    logic [31:0]          got;
    logic [MEM_IDX_W-1:0] idx;
    idx = run_addr[MEM_IDX_W+1:2];
    if (op == OP_WRITE) begin
      write_reg_word(REG_INSTR, wdata);
    end
    write_byte(reg_addr(REG_CMD, 2'd0), {7'd0, op});
    write_byte(reg_addr(REG_STATUS, 2'd0), 8'(1 << ST_INSTR_VALID));
    poll_clear(ST_INSTR_VALID);
    if (op == OP_READ) begin
      read_reg_word(REG_RDATA, got);
      check_val("rdata", got, mem_model[idx]);
    end else begin
      mem_model[idx] = wdata;
    end
    run_addr = run_addr + 32'd4;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
             checks - chk_mark, errors - err_mark);
    err_mark = errors;
    chk_mark = checks;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [7:0]           b;
    logic [31:0]          w;
    logic [31:0]          ww;
    logic [31:0]          got;
    logic [31:0]          a;
    logic [MEM_IDX_W-1:0] bi;
    logic [MEM_IDX_W-1:0] wi;
    bridge_op_e           op;
    logic [MEM_IDX_W-1:0] idxq [$];
    int                   asrt_fails;

    seed                    = 32'hdc40;
    run_addr                = '0;
    usb_addr                = '0;
    usb_wdata               = '0;
    usb_rdn                 = 1'b1;
    usb_wrn                 = 1'b1;
    usb_cen                 = 1'b1;
    rst_instr_valid_to_regs = 1'b0;
    repeat (10) @(posedge heep_clk);
    rst_instr_valid_to_regs <= 1'b1;

    // register readback and status clear after reset
    @(negedge heep_clk);
    check_val("usb_data_o", {24'd0, usb_rdata}, 32'd0);
    read_byte(reg_addr(REG_STATUS, 2'd0), b);
    check_val("status", {24'd0, b}, 32'd0);
    w = rand_word();
    write_reg_word(REG_INSTR, w);
    read_reg_word(REG_INSTR, got);
    check_val("instr", got, w);
    w = rand_word();
    write_reg_word(REG_ADDR, w);
    read_reg_word(REG_ADDR, got);
    check_val("addr", got, w);
    w = rand_word();
    write_byte(reg_addr(REG_CMD, 2'd0), w[7:0]);
    read_byte(reg_addr(REG_CMD, 2'd0), b);
    check_val("cmd", {24'd0, b}, {24'd0, w[7:0]});
    end_test("register readback");

    // address load and a write that lands there
    w = rand_word();
    a = {25'd0, w[6:2], 2'b00};
    load_addr(a);
    run_op(OP_WRITE, rand_word());
    load_addr(a);
    run_op(OP_READ, 32'd0);
    end_test("address load");

    // fill every word through the bridge and read it all back
    w = rand_word();
    a = {25'd0, w[6:2], 2'b00};
    load_addr(a);
    for (int i = 0; i < MEM_WORDS; i++) begin
      run_op(OP_WRITE, rand_word());
    end
    load_addr(a);
    for (int i = 0; i < MEM_WORDS; i++) begin
      run_op(OP_READ, 32'd0);
    end
    end_test("bridge write and read");

    // window words checked through the bridge
    for (int i = 0; i < N_WIN; i++) begin
      w  = rand_word();
      ww = rand_word();
      poll_clear(ST_WIN_BUSY);
      for (int k = 0; k < 4; k++) begin
        write_byte(win_addr(w[4:0], BYTECNT_W'(k)), ww[8*k +: 8]);
      end
      mem_model[w[4:0]] = ww;
      idxq.push_back(w[4:0]);
    end
    poll_clear(ST_WIN_BUSY);
    foreach (idxq[i]) begin
      load_addr({25'd0, idxq[i], 2'b00});
      run_op(OP_READ, 32'd0);
    end
    end_test("window writes");

    // bridge and window aimed at the same cycle on disjoint words
    for (int i = 0; i < N_MIX; i++) begin
      w  = rand_word();
      bi = w[4:0];
      wi = bi ^ 5'h10;
      op = bridge_op_e'(w[8]);
      w  = rand_word();
      ww = rand_word();
      poll_clear(ST_WIN_BUSY);
      write_reg_word(REG_INSTR, w);
      write_byte(reg_addr(REG_CMD, 2'd0), {7'd0, op});
      write_reg_word(REG_ADDR, {25'd0, bi, 2'b00});
      for (int k = 0; k < 3; k++) begin
        write_byte(win_addr(wi, BYTECNT_W'(k)), ww[8*k +: 8]);
      end
      // address load delays the bridge request onto the window request
      write_byte(reg_addr(REG_STATUS, 2'd0), 8'((1 << ST_ADDR_VALID) | (1 << ST_INSTR_VALID)));
      write_byte(win_addr(wi, 2'd3), ww[31:24]);
      mem_model[wi] = ww;
      poll_clear(ST_INSTR_VALID);
      poll_clear(ST_WIN_BUSY);
      if (op == OP_READ) begin
        read_reg_word(REG_RDATA, got);
        check_val("rdata", got, mem_model[bi]);
      end else begin
        mem_model[bi] = w;
      end
      run_addr = {25'd0, bi, 2'b00} + 32'd4;
    end
    // whole memory against the model
    load_addr(32'd0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      run_op(OP_READ, 32'd0);
    end
    end_test("contention");

    // bound bus and flag checkers
    asrt_fails = dut.u_obi_arbiter.u_bus_assert.fail_cnt
               + dut.u_bridge_regs.u_flag_assert.fail_cnt;
    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, asrt_fails);
    if ((errors == 0) && (asrt_fails == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/bridge_regs.sv */
`default_nettype none

module bridge_regs (
  input  wire                                  heep_clk,
  input  wire                                  rst_instr_valid_to_regs,
  input  wire host_reg_pkg::host_acc_t         acc_i,
  output logic [host_reg_pkg::HOST_DATA_W-1:0] rd_byte_o,
  input  wire                                  win_busy_i,
  input  wire                                  bridge_busy_i,
  output logic [obi_pkg::OBI_DATA_W-1:0]       instr_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]       addr_o,
  output host_reg_pkg::bridge_op_e             op_o,
  output logic                                 instr_valid_o,
  output logic                                 addr_valid_o,
  input  wire                                  clr_instr_i,
  input  wire                                  clr_addr_i,
  input  wire  [obi_pkg::OBI_DATA_W-1:0]       rdata_i,
  input  wire                                  rdata_load_i
);
  import host_reg_pkg::*;
  import obi_pkg::*;

  logic [OBI_DATA_W-1:0]  instr_q;
  logic [OBI_DATA_W-1:0]  addr_q;
  logic [OBI_DATA_W-1:0]  rdata_q;
  logic [HOST_DATA_W-1:0] cmd_q;
  logic                   instr_valid_q;
  logic                   addr_valid_q;
  logic [HOST_DATA_W-1:0] status;
  logic [HOST_DATA_W-1:0] rd_mux;
  logic                   st_wr;

  assign st_wr = acc_i.wr && (acc_i.idx == REG_STATUS);

  // ------------------------------------------------------------
  // control registers
  // ------------------------------------------------------------
  // bridge clear wins over a host status write
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      instr_valid_q <= 1'b0;
      addr_valid_q  <= 1'b0;
      cmd_q         <= '0;
    end else begin
      if (clr_instr_i) begin
        instr_valid_q <= 1'b0;
      end else if (st_wr) begin
        instr_valid_q <= acc_i.data[ST_INSTR_VALID];
      end
      if (clr_addr_i) begin
        addr_valid_q <= 1'b0;
      end else if (st_wr) begin
        addr_valid_q <= acc_i.data[ST_ADDR_VALID];
      end
      if (acc_i.wr && (acc_i.idx == REG_CMD)) begin
        cmd_q <= acc_i.data;
      end
    end
  end

  // byte lane writes into the word registers
  always_ff @(posedge heep_clk) begin
    if (acc_i.wr && (acc_i.idx == REG_INSTR)) begin
      instr_q[{acc_i.bytecnt, 3'b000} +: HOST_DATA_W] <= acc_i.data;
    end
    if (acc_i.wr && (acc_i.idx == REG_ADDR)) begin
      addr_q[{acc_i.bytecnt, 3'b000} +: HOST_DATA_W] <= acc_i.data;
    end
    // readback only from the bus
    if (rdata_load_i) begin
      rdata_q <= rdata_i;
    end
  end

  // ------------------------------------------------------------
  // host readback
  // ------------------------------------------------------------
  // busy bits are live
  always_comb begin
    status                 = '0;
    status[ST_BUSY]        = bridge_busy_i;
    status[ST_INSTR_VALID] = instr_valid_q;
    status[ST_ADDR_VALID]  = addr_valid_q;
    status[ST_WIN_BUSY]    = win_busy_i;
  end

  always_comb begin
    case (acc_i.idx)
      REG_INSTR:  rd_mux = instr_q[{acc_i.bytecnt, 3'b000} +: HOST_DATA_W];
      REG_ADDR:   rd_mux = addr_q[{acc_i.bytecnt, 3'b000} +: HOST_DATA_W];
      REG_CMD:    rd_mux = cmd_q;
      REG_RDATA:  rd_mux = rdata_q[{acc_i.bytecnt, 3'b000} +: HOST_DATA_W];
      REG_STATUS: rd_mux = status;
      default:    rd_mux = '0;
    endcase
  end

  assign rd_byte_o = acc_i.rd ? rd_mux : '0;

  // to the bridge
  assign instr_o       = instr_q;
  assign addr_o        = addr_q;
  assign op_o          = bridge_op_e'(cmd_q[0]);
  assign instr_valid_o = instr_valid_q;
  assign addr_valid_o  = addr_valid_q;

endmodule

`default_nettype wire

/* verilog/cw_bridge_top.sv */
`default_nettype none

module cw_bridge_top (
  input  wire                                  heep_clk,
  input  wire                                  rst_instr_valid_to_regs,
  input  wire  [host_reg_pkg::HOST_ADDR_W-1:0] usb_addr_i,
  input  wire  [host_reg_pkg::HOST_DATA_W-1:0] usb_data_i,
  input  wire                                  usb_rdn_i,
  input  wire                                  usb_wrn_i,
  input  wire                                  usb_cen_i,
  output logic [host_reg_pkg::HOST_DATA_W-1:0] usb_data_o
);
  import host_reg_pkg::*;
  import obi_pkg::*;

  // ------------------------------------------------------------
  // host side
  // ------------------------------------------------------------
  host_acc_t              acc;
  logic [HOST_DATA_W-1:0] rd_byte;
  logic                   win_busy;

  // ------------------------------------------------------------
  // bridge and bus
  // ------------------------------------------------------------
  logic [OBI_DATA_W-1:0] instr;
  logic [OBI_DATA_W-1:0] sect_addr;
  logic [OBI_DATA_W-1:0] rdata;
  bridge_op_e            op;
  logic                  instr_valid;
  logic                  addr_valid;
  logic                  clr_instr;
  logic                  clr_addr;
  logic                  bridge_busy;
  logic                  rdata_load;
  obi_req_t              bridge_req;
  obi_req_t              win_req;
  obi_req_t              mem_req;
  obi_resp_t             bridge_resp;
  obi_resp_t             win_resp;
  obi_resp_t             mem_resp;

  usb_reg_fe u_usb_reg_fe (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .usb_addr_i              (usb_addr_i),
    .usb_data_i              (usb_data_i),
    .usb_rdn_i               (usb_rdn_i),
    .usb_wrn_i               (usb_wrn_i),
    .usb_cen_i               (usb_cen_i),
    .usb_data_o              (usb_data_o),
    .rd_byte_i               (rd_byte),
    .acc_o                   (acc),
    .win_req_o               (win_req),
    .win_gnt_i               (win_resp.gnt),
    .win_busy_o              (win_busy)
  );

  bridge_regs u_bridge_regs (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .acc_i                   (acc),
    .rd_byte_o               (rd_byte),
    .win_busy_i              (win_busy),
    .bridge_busy_i           (bridge_busy),
    .instr_o                 (instr),
    .addr_o                  (sect_addr),
    .op_o                    (op),
    .instr_valid_o           (instr_valid),
    .addr_valid_o            (addr_valid),
    .clr_instr_i             (clr_instr),
    .clr_addr_i              (clr_addr),
    .rdata_i                 (rdata),
    .rdata_load_i            (rdata_load)
  );

  obi_bridge u_obi_bridge (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .instr_i                 (instr),
    .addr_i                  (sect_addr),
    .op_i                    (op),
    .instr_valid_i           (instr_valid),
    .addr_valid_i            (addr_valid),
    .clr_instr_o             (clr_instr),
    .clr_addr_o              (clr_addr),
    .busy_o                  (bridge_busy),
    .rdata_o                 (rdata),
    .rdata_load_o            (rdata_load),
    .req_o                   (bridge_req),
    .resp_i                  (bridge_resp)
  );

  // bridge is master 0, window master 1
  obi_arbiter u_obi_arbiter (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .m0_req_i                (bridge_req),
    .m1_req_i                (win_req),
    .m0_resp_o               (bridge_resp),
    .m1_resp_o               (win_resp),
    .s_req_o                 (mem_req),
    .s_resp_i                (mem_resp)
  );

  word_mem u_word_mem (
    .heep_clk (heep_clk),
    .s_req_i  (mem_req),
    .s_resp_o (mem_resp)
  );

endmodule

`default_nettype wire

/* verilog/host_reg_pkg.sv */
`default_nettype none

package host_reg_pkg;

  // ------------------------------------------------------------
  // host port geometry
  // ------------------------------------------------------------
  // addr[7] selects the window, addr[6:2] the register or word index
  localparam int HOST_ADDR_W = 8;
  localparam int HOST_DATA_W = 8;
  localparam int BYTECNT_W   = 2;
  localparam int REG_IDX_W   = HOST_ADDR_W - BYTECNT_W - 1;
  localparam int WIN_SEL_BIT = HOST_ADDR_W - 1;

  // register map, word registers take 4 bytes
  localparam logic [REG_IDX_W-1:0] REG_INSTR  = 5'd0;
  localparam logic [REG_IDX_W-1:0] REG_ADDR   = 5'd1;
  localparam logic [REG_IDX_W-1:0] REG_CMD    = 5'd2;
  localparam logic [REG_IDX_W-1:0] REG_RDATA  = 5'd3;
  localparam logic [REG_IDX_W-1:0] REG_STATUS = 5'd4;

  // status byte bit positions
  localparam int ST_BUSY        = 0;
  localparam int ST_INSTR_VALID = 1;
  localparam int ST_ADDR_VALID  = 2;
  localparam int ST_WIN_BUSY    = 3;

  // command opcodes, bit 0 of the command byte
  typedef enum logic [0:0] {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } bridge_op_e;

  // one decoded register access from the front end
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [REG_IDX_W-1:0]   idx;
    logic [BYTECNT_W-1:0]   bytecnt;
    logic [HOST_DATA_W-1:0] data;
  } host_acc_t;

endpackage

`default_nettype wire

/* verilog/obi_arbiter.sv */
`default_nettype none

module obi_arbiter (
  input  wire                     heep_clk,
  input  wire                     rst_instr_valid_to_regs,
  input  wire obi_pkg::obi_req_t  m0_req_i,
  input  wire obi_pkg::obi_req_t  m1_req_i,
  output obi_pkg::obi_resp_t      m0_resp_o,
  output obi_pkg::obi_resp_t      m1_resp_o,
  output obi_pkg::obi_req_t       s_req_o,
  input  wire obi_pkg::obi_resp_t s_resp_i
);
  import obi_pkg::*;

  // 1 means m1 won
  logic last_q;
  logic owner_q;
  logic sel_m1;

  // m1 on its own, or on a tie when m0 went last
  assign sel_m1 = m1_req_i.req && (!m0_req_i.req || !last_q);

  assign s_req_o = sel_m1 ? m1_req_i : m0_req_i;

  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      last_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      if (s_resp_i.gnt) begin
        last_q <= sel_m1;
      end
      // rvalid comes one cycle after gnt
      owner_q <= sel_m1;
    end
  end

  // ------------------------------------------------------------
  // response routing
  // ------------------------------------------------------------
  always_comb begin
    m0_resp_o.gnt    = s_resp_i.gnt && !sel_m1;
    m0_resp_o.rvalid = s_resp_i.rvalid && !owner_q;
    m0_resp_o.rdata  = s_resp_i.rdata;
    m1_resp_o.gnt    = s_resp_i.gnt && sel_m1;
    m1_resp_o.rvalid = s_resp_i.rvalid && owner_q;
    m1_resp_o.rdata  = s_resp_i.rdata;
  end

endmodule

`default_nettype wire

/* verilog/obi_bridge.sv */
`default_nettype none

module obi_bridge (
  input  wire                            heep_clk,
  input  wire                            rst_instr_valid_to_regs,
  input  wire  [obi_pkg::OBI_DATA_W-1:0] instr_i,
  input  wire  [obi_pkg::OBI_DATA_W-1:0] addr_i,
  input  wire host_reg_pkg::bridge_op_e  op_i,
  input  wire                            instr_valid_i,
  input  wire                            addr_valid_i,
  output logic                           clr_instr_o,
  output logic                           clr_addr_o,
  output logic                           busy_o,
  output logic [obi_pkg::OBI_DATA_W-1:0] rdata_o,
  output logic                           rdata_load_o,
  output obi_pkg::obi_req_t              req_o,
  input  wire obi_pkg::obi_resp_t        resp_i
);
  import host_reg_pkg::*;
  import obi_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_ADDR,
    REQ,
    WAIT_RVALID,
    DONE
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic [OBI_ADDR_W-1:0] run_addr_q;
  logic                  advance;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      // address load first
      IDLE: begin
        if (addr_valid_i) begin
          state_d = LOAD_ADDR;
        end else if (instr_valid_i) begin
          state_d = REQ;
        end
      end
      LOAD_ADDR: state_d = IDLE;
      // writes finish at grant, reads wait for data
      REQ: begin
        if (resp_i.gnt) begin
          state_d = (op_i == OP_READ) ? WAIT_RVALID : DONE;
        end
      end
      WAIT_RVALID: begin
        if (resp_i.rvalid) begin
          state_d = IDLE;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // end of one operation
  assign advance = (state_q == DONE) || ((state_q == WAIT_RVALID) && resp_i.rvalid);

  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      state_q    <= IDLE;
      run_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == LOAD_ADDR) begin
        run_addr_q <= addr_i;
      end else if (advance) begin
        run_addr_q <= run_addr_q + OBI_ADDR_W'(4);
      end
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign clr_addr_o   = (state_q == LOAD_ADDR);
  assign clr_instr_o  = advance;
  assign busy_o       = (state_q != IDLE);
  assign rdata_o      = resp_i.rdata;
  assign rdata_load_o = (state_q == WAIT_RVALID) && resp_i.rvalid;

  // all bytes enabled for both opcodes
  always_comb begin
    req_o.req   = (state_q == REQ);
    req_o.we    = (op_i == OP_WRITE);
    req_o.be    = '1;
    req_o.addr  = run_addr_q;
    req_o.wdata = instr_i;
  end

endmodule

`default_nettype wire

/* verilog/obi_pkg.sv */
`default_nettype none

package obi_pkg;

  // ------------------------------------------------------------
  // memory bus widths
  // ------------------------------------------------------------
  localparam int OBI_ADDR_W = 32;
  localparam int OBI_DATA_W = 32;
  localparam int OBI_BE_W   = OBI_DATA_W / 8;

  // word memory, indexed by addr[6:2]
  localparam int MEM_WORDS = 32;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // master to slave, held stable until gnt
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [OBI_BE_W-1:0]   be;
    logic [OBI_ADDR_W-1:0] addr;
    logic [OBI_DATA_W-1:0] wdata;
  } obi_req_t;

  // slave to master
  // gnt in the request cycle, rvalid one cycle later
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [OBI_DATA_W-1:0] rdata;
  } obi_resp_t;

endpackage

`default_nettype wire

/* verilog/usb_reg_fe.sv */
`default_nettype none

module usb_reg_fe (
  input  wire                                  heep_clk,
  input  wire                                  rst_instr_valid_to_regs,
  input  wire  [host_reg_pkg::HOST_ADDR_W-1:0] usb_addr_i,
  input  wire  [host_reg_pkg::HOST_DATA_W-1:0] usb_data_i,
  input  wire                                  usb_rdn_i,
  input  wire                                  usb_wrn_i,
  input  wire                                  usb_cen_i,
  output logic [host_reg_pkg::HOST_DATA_W-1:0] usb_data_o,
  input  wire  [host_reg_pkg::HOST_DATA_W-1:0] rd_byte_i,
  output host_reg_pkg::host_acc_t              acc_o,
  output obi_pkg::obi_req_t                    win_req_o,
  input  wire                                  win_gnt_i,
  output logic                                 win_busy_o
);
  import host_reg_pkg::*;
  import obi_pkg::*;

  logic [HOST_ADDR_W-1:0] addr_q;
  logic [HOST_DATA_W-1:0] data_q;
  logic                   rdn_q;
  logic                   wrn_q;
  logic                   cen_q;
  logic                   wr_act_q;
  logic                   wr_act;
  logic                   rd_act;
  logic                   wr_pulse;
  logic                   win_sel;
  logic                   win_wr;
  logic [REG_IDX_W-1:0]   win_idx_q;
  logic [OBI_DATA_W-1:0]  win_buf_q;
  logic                   win_pend_q;

  // ------------------------------------------------------------
  // input sampling and strobe decode
  // ------------------------------------------------------------
  // strobes idle high
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      rdn_q    <= 1'b1;
      wrn_q    <= 1'b1;
      cen_q    <= 1'b1;
      wr_act_q <= 1'b0;
    end else begin
      rdn_q    <= usb_rdn_i;
      wrn_q    <= usb_wrn_i;
      cen_q    <= usb_cen_i;
      wr_act_q <= wr_act;
    end
  end

  always_ff @(posedge heep_clk) begin
    addr_q <= usb_addr_i;
    data_q <= usb_data_i;
  end

  assign wr_act   = ~wrn_q & ~cen_q;
  assign rd_act   = ~rdn_q & ~cen_q;
  // one pulse per write strobe
  assign wr_pulse = wr_act & ~wr_act_q;
  assign win_sel  = addr_q[WIN_SEL_BIT];
  // window writes dropped while a word waits for its grant
  assign win_wr   = wr_pulse & win_sel & ~win_pend_q;

  // register side access
  always_comb begin
    acc_o.wr      = wr_pulse & ~win_sel;
    acc_o.rd      = rd_act & ~win_sel;
    acc_o.idx     = addr_q[WIN_SEL_BIT-1:BYTECNT_W];
    acc_o.bytecnt = addr_q[BYTECNT_W-1:0];
    acc_o.data    = data_q;
  end

  // read byte lands one cycle after the sampled strobe
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      usb_data_o <= '0;
    end else if (acc_o.rd) begin
      usb_data_o <= rd_byte_i;
    end
  end

  // ------------------------------------------------------------
  // window word assembly
  // ------------------------------------------------------------
  // byte 3 closes the word and raises the request
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      win_pend_q <= 1'b0;
    end else if (win_gnt_i) begin
      win_pend_q <= 1'b0;
    end else if (win_wr && (acc_o.bytecnt == '1)) begin
      win_pend_q <= 1'b1;
    end
  end

  always_ff @(posedge heep_clk) begin
    if (win_wr) begin
      win_buf_q[{acc_o.bytecnt, 3'b000} +: HOST_DATA_W] <= data_q;
      if (acc_o.bytecnt == '1) begin
        win_idx_q <= acc_o.idx;
      end
    end
  end

  // full word write, held from registers until gnt
  always_comb begin
    win_req_o.req   = win_pend_q;
    win_req_o.we    = 1'b1;
    win_req_o.be    = '1;
    win_req_o.addr  = OBI_ADDR_W'({win_idx_q, 2'b00});
    win_req_o.wdata = win_buf_q;
  end

  assign win_busy_o = win_pend_q;

endmodule

`default_nettype wire

/* verilog/word_mem.sv */
`default_nettype none

module word_mem (
  input  wire                    heep_clk,
  input  wire obi_pkg::obi_req_t s_req_i,
  output obi_pkg::obi_resp_t     s_resp_o
);
  import obi_pkg::*;

  logic [OBI_DATA_W-1:0] mem [MEM_WORDS];
  logic [MEM_IDX_W-1:0]  idx;
  logic                  rvalid_q;
  logic [OBI_DATA_W-1:0] rdata_q;

  // word index from addr[6:2]
  assign idx = s_req_i.addr[MEM_IDX_W+1:2];

  // byte enabled write
  always_ff @(posedge heep_clk) begin
    if (s_req_i.req && s_req_i.we) begin
      for (int b = 0; b < OBI_BE_W; b++) begin
        if (s_req_i.be[b]) begin
          mem[idx][8*b +: 8] <= s_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // response one cycle after every grant
  always_ff @(posedge heep_clk) begin
    rvalid_q <= s_req_i.req;
    if (s_req_i.req && !s_req_i.we) begin
      rdata_q <= mem[idx];
    end
  end

  // always ready
  always_comb begin
    s_resp_o.gnt    = s_req_i.req;
    s_resp_o.rvalid = rvalid_q;
    s_resp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire

/* vlog.f */
verilog/host_reg_pkg.sv
verilog/obi_pkg.sv
verilog/usb_reg_fe.sv
verilog/bridge_regs.sv
verilog/obi_bridge.sv
verilog/obi_arbiter.sv
verilog/word_mem.sv
verilog/cw_bridge_top.sv
test/bridge_assert.sv
test/tb_top.sv
